// File: sprite_macros.svh
`ifndef SPRITE_MACROS_SVH
`define SPRITE_MACROS_SVH

////////////////////
// sprite geometry
////////////////////

`define SPRITE_COUNT 10 // sprites held in the memory
`define SPRITE_ROWS 16 // pixel rows per sprite
`define SPRITE_COLS 16 // pixel columns per sprite

////////////////////
// memory layout
////////////////////

`define PIXELS_PER_WORD 3 // three rbg pixels per word
`define WORDS_PER_ROW 6 // last word of a row holds one pixel only
`define WORDS_PER_SPRITE 96 // 16 rows of 6 words
`define RAM_DEPTH 960 // ten sprites back to back

////////////////////
// widths
////////////////////

`define COLOR_BITS 3 // r, b, g
`define WORD_BITS 9 // PIXELS_PER_WORD * COLOR_BITS
`define ADDR_BITS 10 // covers RAM_DEPTH
`define SUB_BITS 5 // superpixel coordinate, 0..31
`define PIC_BITS 4 // sprite number, 10..15 shows black
`define SLOT_BITS 2 // pixel index inside a word

`endif

// File: spritePkg.sv
`include "sprite_macros.svh"

package spritePkg;

	////////////////////
	// coordinate side
	////////////////////

	// one superpixel coordinate, strobed by coordValid
	typedef struct packed
	{
		logic [`PIC_BITS-1:0] picNum; // sprite number
		logic [`SUB_BITS-1:0] xSub; // sub-column, two per sprite column
		logic [`SUB_BITS-1:0] ySub; // sub-row, two per sprite row
	} spriteCoord_t;

	// rides alongside the memory read
	typedef struct packed
	{
		logic [`SLOT_BITS-1:0] slot; // 0 is the top field of the word
		logic valid; // coordinate was strobed
		logic inRange; // picNum below SPRITE_COUNT
	} fetchTag_t;

	////////////////////
	// pixel side
	////////////////////

	// same bit order as a field in memory
	typedef struct packed
	{
		logic r;
		logic b;
		logic g;
	} rgbPixel_t;

	// external load port of the sprite memory
	typedef struct packed
	{
		logic [`ADDR_BITS-1:0] addr; // word address
		logic [`WORD_BITS-1:0] data; // three packed pixels
	} spriteWrite_t;

endpackage

// File: spriteAddrGen.sv
`timescale 1ns/1ps
`include "sprite_macros.svh"

module spriteAddrGen
(
	input spritePkg::spriteCoord_t coord,
	input logic coordValid,
	output logic [`ADDR_BITS-1:0] readAddr,
	output spritePkg::fetchTag_t tag
);

	localparam int AW = `ADDR_BITS;
	localparam int ROW_BITS = $clog2(`SPRITE_ROWS); // 4 for 16 rows
	localparam int COL_BITS = $clog2(`SPRITE_COLS); // 4 for 16 columns

	logic [ROW_BITS-1:0] pixRow; // sprite row
	logic [COL_BITS-1:0] pixCol; // sprite column
	logic [COL_BITS-1:0] wordIdx; // word within the row, 0..5
	logic [COL_BITS-1:0] slotFull; // col mod 3 before narrowing
	logic [AW-1:0] spriteBase; // first word of the sprite
	logic [AW-1:0] rowBase; // row offset inside the sprite
	logic inRange;

	////////////////////
	// coordinate decode
	////////////////////

	always_comb
	begin
		pixRow = coord.ySub[`SUB_BITS-1:1]; // drop lsb, each pixel is 2 lines tall
		pixCol = coord.xSub[`SUB_BITS-1:1]; // and 2 columns wide
		wordIdx = pixCol / COL_BITS'(`PIXELS_PER_WORD);
		slotFull = pixCol % COL_BITS'(`PIXELS_PER_WORD);
	end

	////////////////////
	// address build
	////////////////////

	always_comb
	begin
		inRange = coord.picNum < `PIC_BITS'(`SPRITE_COUNT);
		spriteBase = AW'(coord.picNum) * AW'(`WORDS_PER_SPRITE); // wraps above 9, masked below
		rowBase = AW'(pixRow) * AW'(`WORDS_PER_ROW);

		// highest legal sum is 9*96 + 15*6 + 5 = 959
		if (inRange)
		begin
			readAddr = spriteBase + rowBase + AW'(wordIdx);
		end
		else
		begin
			readAddr = '0; // park on word 0, pixel is blanked later anyway
		end
	end

	////////////////////
	// tag for the pixel stage
	////////////////////

	always_comb
	begin
		tag.slot = slotFull[`SLOT_BITS-1:0]; // 0..2 only
		tag.valid = coordValid;
		tag.inRange = inRange;
	end

endmodule

// File: spriteRam.sv
`timescale 1ns/1ps
`include "sprite_macros.svh"

module spriteRam
(
	input logic clk,
	input logic writeStrobe,
	input spritePkg::spriteWrite_t memWrite,
	input logic [`ADDR_BITS-1:0] readAddr,
	output logic [`WORD_BITS-1:0] readData
);

	localparam int AW = `ADDR_BITS;

	// 960 words, plain array so it maps onto block ram
	logic [`WORD_BITS-1:0] mem [`RAM_DEPTH];

	logic writeOk; // strobe and address inside the array

	////////////////////
	// write port
	////////////////////

	// addresses 960..1023 have no storage
	always_comb
	begin
		writeOk = writeStrobe && (memWrite.addr < AW'(`RAM_DEPTH));
	end

	always_ff @(posedge clk)
	begin
		if (writeOk)
		begin
			mem[memWrite.addr] <= memWrite.data; // lands on this edge
		end
	end

	////////////////////
	// read port
	////////////////////

	// registered read, one edge of latency
	// a same-edge write is not seen, the next read gets the new word
	always_ff @(posedge clk)
	begin
		readData <= mem[readAddr];
	end

endmodule

// File: pixelSelect.sv
`timescale 1ns/1ps
`include "sprite_macros.svh"

module pixelSelect
(
	input logic clk,
	input logic arstN,
	input spritePkg::fetchTag_t tag,
	input logic [`WORD_BITS-1:0] readData,
	output spritePkg::rgbPixel_t pixel,
	output logic pixelValid
);

	localparam int CB = `COLOR_BITS;

	spritePkg::fetchTag_t tagQ; // tag of the word now on readData
	spritePkg::rgbPixel_t field; // slot picked out of the word
	spritePkg::rgbPixel_t pixelNext; // blanked version of field

	////////////////////
	// tag delay
	////////////////////

	// matches the one-edge memory read
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			tagQ <= '0; // no valid in flight
		end
		else
		begin
			tagQ <= tag;
		end
	end

	////////////////////
	// slot mux
	////////////////////

	always_comb
	begin
		case (tagQ.slot)
			2'd0: field = readData[`WORD_BITS-1 -: CB]; // first pixel, top bits
			2'd1: field = readData[`WORD_BITS-1-CB -: CB]; // middle
			2'd2: field = readData[CB-1:0]; // last pixel, low bits
			default: field = '0; // slot 3 never decoded
		endcase

		// black for sprites 10..15 and for idle cycles
		if (tagQ.valid && tagQ.inRange)
		begin
			pixelNext = field;
		end
		else
		begin
			pixelNext = '0;
		end
	end

	////////////////////
	// output register
	////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			pixel <= '0;
			pixelValid <= 1'b0;
		end
		else
		begin
			pixel <= pixelNext;
			pixelValid <= tagQ.valid; // high even when out of range
		end
	end

endmodule

// File: spriteBitGen.sv
`timescale 1ns/1ps
`include "sprite_macros.svh"

module spriteBitGen
(
	input logic clk,
	input logic arstN,
	input spritePkg::spriteCoord_t coord, // sprite number and sub-coordinates
	input logic coordValid, // one pulse per coordinate
	input logic writeStrobe, // load strobe for memWrite
	input spritePkg::spriteWrite_t memWrite,
	output spritePkg::rgbPixel_t pixel, // two edges after coordValid
	output logic pixelValid
);

	////////////////////
	// internal wires
	////////////////////

	logic [`ADDR_BITS-1:0] readAddr; // combinational from the decoder
	spritePkg::fetchTag_t tag; // slot and flags for the same read
	logic [`WORD_BITS-1:0] readData; // registered memory word

	////////////////////
	// address decode
	////////////////////

	spriteAddrGen addrGen_i
	(
		.coord(coord),
		.coordValid(coordValid),
		.readAddr(readAddr),
		.tag(tag)
	);

	////////////////////
	// sprite memory
	////////////////////

	spriteRam ram_i
	(
		.clk(clk),
		.writeStrobe(writeStrobe),
		.memWrite(memWrite),
		.readAddr(readAddr),
		.readData(readData)
	);

	////////////////////
	// pixel pick and output register
	////////////////////

	pixelSelect select_i
	(
		.clk(clk),
		.arstN(arstN),
		.tag(tag),
		.readData(readData),
		.pixel(pixel),
		.pixelValid(pixelValid)
	);

endmodule

// File: tbSpriteBitGen.sv
`timescale 1ns/1ps
`include "sprite_macros.svh"

module tbSpriteBitGen;

	localparam int CLK_PERIOD = 100; // ns
	localparam int RESET_CYCLES = 8;
	localparam int SEED = 45;
	localparam int COORD_BITS = $bits(spritePkg::spriteCoord_t);
	localparam int SCAN_COORDS = 32 * 32; // every sub-coordinate of one sprite
	localparam int DOUBLE_GROUPS = 16; // four coordinates per group
	localparam int RANDOM_COORDS = 2000;
	localparam int OOR_PER_PIC = 4; // coordinates per sprite 10..15
	localparam int DRAIN_CYCLES = 4; // idle tail after each test
	// random test strobes 3 of 4 cycles on average
	localparam int TEST_CYCLES = RESET_CYCLES + 32 + `RAM_DEPTH + 2 + SCAN_COORDS
		+ DOUBLE_GROUPS * 4 + RANDOM_COORDS * 4 / 3 + 6 * OOR_PER_PIC + 8
		+ 6 * DRAIN_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES; // roughly 10k cycles

	// one expected output cycle
	typedef struct packed
	{
		logic valid;
		logic same; // pixel must repeat the one before it
		spritePkg::rgbPixel_t pix;
	} expEntry_t;

	logic clk;
	logic arstN;
	spritePkg::spriteCoord_t coord;
	logic coordValid;
	logic writeStrobe;
	spritePkg::spriteWrite_t memWrite;
	spritePkg::rgbPixel_t pixel;
	logic pixelValid;

	logic sameFlag; // doubling test marks repeats
	logic forceOn; // rewrite test gives its own expected pixel
	spritePkg::rgbPixel_t forcePix;

	logic [`WORD_BITS-1:0] shadow [`RAM_DEPTH]; // model of the sprite memory
	expEntry_t expQ [$]; // two cycles of expected outputs
	expEntry_t nextExp;
	expEntry_t curExp; // what the outputs must show now

	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testCount = 0;
	int failTests = 0;

	////////////////////
	// clock and DUT
	////////////////////

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	spriteBitGen dut_i
	(
		.clk(clk),
		.arstN(arstN),
		.coord(coord),
		.coordValid(coordValid),
		.writeStrobe(writeStrobe),
		.memWrite(memWrite),
		.pixel(pixel),
		.pixelValid(pixelValid)
	);

	////////////////////
	// reference model
	////////////////////

	// slot 0 sits in the top bits of the word
	function automatic spritePkg::rgbPixel_t fieldOf(input logic [`WORD_BITS-1:0] word,
		input int slot);
		int shift;
		shift = (`PIXELS_PER_WORD - 1 - slot) * `COLOR_BITS;
		return spritePkg::rgbPixel_t'(`COLOR_BITS'(word >> shift));
	endfunction

	function automatic spritePkg::rgbPixel_t modelPixel(input spritePkg::spriteCoord_t c);
		int row;
		int col;
		logic [`ADDR_BITS-1:0] addr;
		if (int'(c.picNum) >= `SPRITE_COUNT)
		begin
			return '0; // no sprite there, black
		end
		row = int'(c.ySub) / 2; // 2x2 superpixels
		col = int'(c.xSub) / 2;
		addr = `ADDR_BITS'(int'(c.picNum) * `WORDS_PER_SPRITE + row * `WORDS_PER_ROW
			+ col / `PIXELS_PER_WORD);
		return fieldOf(shadow[addr], col % `PIXELS_PER_WORD);
	endfunction

	// follows the inputs edge by edge, output lags by two edges
	always @(posedge clk)
	begin
		if (!arstN)
		begin
			expQ.delete();
			curExp = '0;
		end
		else
		begin
			nextExp.valid = coordValid;
			nextExp.same = coordValid && sameFlag;
			if (!coordValid)
			begin
				nextExp.pix = '0;
			end
			else if (forceOn)
			begin
				nextExp.pix = forcePix;
			end
			else
			begin
				nextExp.pix = modelPixel(coord); // read before this edge's write
			end
			if (writeStrobe && int'(memWrite.addr) < `RAM_DEPTH)
			begin
				shadow[memWrite.addr] = memWrite.data;
			end
			expQ.push_back(nextExp);
			if (expQ.size() > 2)
			begin
				void'(expQ.pop_front());
			end
			if (expQ.size() == 2)
			begin
				curExp = expQ[0];
			end
			else
			begin
				curExp = '0; // pipe still filling after reset
			end
		end
	end

	////////////////////
	// checks
	////////////////////

	// outputs change on the rising edge, sampled on the falling one
	validCheck : assert property (@(negedge clk) pixelValid == curExp.valid)
	else
	begin
		errorCount++;
		$display("ERROR pixelValid: got 0x%h, expected 0x%h (cycle %0d)",
			pixelValid, curExp.valid, cycleCount);
	end

	pixelCheck : assert property (@(negedge clk) pixel == curExp.pix)
	else
	begin
		errorCount++;
		$display("ERROR pixel: got 0x%h, expected 0x%h (cycle %0d)",
			pixel, curExp.pix, cycleCount);
	end

	// same superpixel pair, same colour
	pairCheck : assert property (@(negedge clk) curExp.same |-> pixel == $past(pixel))
	else
	begin
		errorCount++;
		$display("ERROR pixel: got 0x%h, expected 0x%h from its pair (cycle %0d)",
			pixel, $past(pixel), cycleCount);
	end

	always @(negedge clk)
	begin
		checkCount++;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("timeout: tests still running after %0d cycles", cycleCount);
			$display("test failed");
			$finish;
		end
	end

	////////////////////
	// stimulus tasks
	////////////////////

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(negedge clk);
			coord = COORD_BITS'($urandom); // junk, no strobe
			coordValid = 1'b0;
			writeStrobe = 1'b0;
			sameFlag = 1'b0;
			forceOn = 1'b0;
		end
	endtask

	task automatic driveCoord(input int pic, input int x, input int y, input logic same);
		@(negedge clk);
		coord.picNum = `PIC_BITS'(pic);
		coord.xSub = `SUB_BITS'(x);
		coord.ySub = `SUB_BITS'(y);
		coordValid = 1'b1;
		writeStrobe = 1'b0;
		sameFlag = same;
		forceOn = 1'b0;
	endtask

	task automatic driveExpected(input int pic, input int x, input int y,
		input spritePkg::rgbPixel_t pix);
		driveCoord(pic, x, y, 1'b0);
		forceOn = 1'b1; // overrides the model for this coordinate
		forcePix = pix;
	endtask

	task automatic writeWord(input int addr, input int data);
		@(negedge clk);
		memWrite.addr = `ADDR_BITS'(addr);
		memWrite.data = `WORD_BITS'(data);
		writeStrobe = 1'b1;
		coordValid = 1'b0;
		sameFlag = 1'b0;
		forceOn = 1'b0;
	endtask

	// drain the pipe, then one line for the test
	task automatic finishTest(input string name, input int errBefore);
		idleCycles(DRAIN_CYCLES);
		testCount++;
		if (errorCount == errBefore)
		begin
			$display("%s: ok", name);
		end
		else
		begin
			failTests++;
			$display("%s: %0d errors", name, errorCount - errBefore);
		end
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial
	begin
		logic [`ADDR_BITS-1:0] rewriteAddr;
		logic [`WORD_BITS-1:0] newData;
		int n;
		int errBefore;
		void'($urandom(SEED));
		arstN = 1'b0;
		coord = '0;
		coordValid = 1'b0;
		writeStrobe = 1'b0;
		memWrite = '0;
		sameFlag = 1'b0;
		forceOn = 1'b0;
		forcePix = '0;

		// reset, then idle with junk on coord
		errBefore = errorCount;
		repeat (RESET_CYCLES) @(negedge clk);
		arstN = 1'b1;
		idleCycles(32);
		finishTest("reset and idle", errBefore);

		// load every word, then scan sprite 0 back to back
		errBefore = errorCount;
		for (int a = 0; a < `RAM_DEPTH; a++)
		begin
			writeWord(a, int'($urandom % (1 << `WORD_BITS)));
		end
		idleCycles(2);
		for (int y = 0; y < 32; y++)
		begin
			for (int x = 0; x < 32; x++)
			begin
				driveCoord(0, x, y, 1'b0);
			end
		end
		finishTest("full sprite scan", errBefore);

		// 2k and 2k+1 in both axes
		errBefore = errorCount;
		for (int g = 0; g < DOUBLE_GROUPS; g++)
		begin
			int pic;
			int k;
			int l;
			pic = int'($urandom % `SPRITE_COUNT);
			k = int'($urandom % `SPRITE_COLS);
			l = int'($urandom % `SPRITE_ROWS);
			driveCoord(pic, 2 * k, 2 * l, 1'b0);
			driveCoord(pic, 2 * k + 1, 2 * l, 1'b1);
			driveCoord(pic, 2 * k, 2 * l + 1, 1'b1);
			driveCoord(pic, 2 * k + 1, 2 * l + 1, 1'b1);
		end
		finishTest("pixel doubling", errBefore);

		// gapped strobes over sprites 0..9
		errBefore = errorCount;
		n = 0;
		while (n < RANDOM_COORDS)
		begin
			if ($urandom % 4 != 0)
			begin
				driveCoord(int'($urandom % `SPRITE_COUNT), int'($urandom % 32),
					int'($urandom % 32), 1'b0);
				n++;
			end
			else
			begin
				idleCycles(1);
			end
		end
		finishTest("random coordinates", errBefore);

		// sprites 10..15 are valid but black
		errBefore = errorCount;
		for (int pic = `SPRITE_COUNT; pic < (1 << `PIC_BITS); pic++)
		begin
			repeat (OOR_PER_PIC)
			begin
				driveExpected(pic, int'($urandom % 32), int'($urandom % 32), '0);
			end
		end
		finishTest("out-of-range sprites", errBefore);

		// sprite 3, row 7, word 2 gets inverted data
		errBefore = errorCount;
		rewriteAddr = `ADDR_BITS'(3 * `WORDS_PER_SPRITE + 7 * `WORDS_PER_ROW + 2);
		newData = ~shadow[rewriteAddr]; // every slot changes
		writeWord(int'(rewriteAddr), int'(newData));
		for (int s = 0; s < `PIXELS_PER_WORD; s++)
		begin
			driveExpected(3, 2 * (2 * `PIXELS_PER_WORD + s), 2 * 7, fieldOf(newData, s));
		end
		finishTest("rewrite", errBefore);

		$display("%0d tests, %0d failing, %0d errors, %0d cycles checked",
			testCount, failTests, errorCount, checkCount);
		if (errorCount == 0 && failTests == 0)
		begin
			$display("test passed");
		end
		else
		begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
spritePkg.sv
spriteAddrGen.sv
spriteRam.sv
pixelSelect.sv
spriteBitGen.sv
tbSpriteBitGen.sv

// File: runSim.sh
#!/bin/sh
# build the sprite testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module tbSpriteBitGen \
	-f filelist.f \
	-o simSprite

./obj_dir/simSprite > sim.log 2>&1
cat sim.log

if grep -qx "test passed" sim.log; then
	echo "simulation ok, see sim.log"
else
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
